/* logic/bus_defs.svh */
`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

// Bus widths
`define BUS_ADDR_W 16
`define BUS_DATA_W 8

// Number of targets on the shared bus
`define BUS_NUM_TGT 3

// Target 0 region
`define TGT0_BASE 16'h0000
`define TGT0_SIZE 2048

// Target 1 region
`define TGT1_BASE 16'h4000
`define TGT1_SIZE 4096

// Target 2 region
`define TGT2_BASE 16'h8000
`define TGT2_SIZE 4096

`endif

/* logic/bus_pkg.sv */
`include "bus_defs.svh"

package bus_pkg;

    // Command as issued by an initiator
    typedef struct packed {
        logic [`BUS_ADDR_W-1:0] addr;
        logic [`BUS_DATA_W-1:0] wdata;
        logic                   write;
    } bus_cmd_t;

    // Response returned to the owning initiator
    typedef struct packed {
        logic [`BUS_DATA_W-1:0] rdata;
        logic                   err;
    } bus_rsp_t;

    // Command as seen by a target, offset is region relative
    typedef struct packed {
        logic [`BUS_ADDR_W-1:0] offset;
        logic [`BUS_DATA_W-1:0] wdata;
        logic                   write;
    } tgt_cmd_t;

    // One-hot target select
    typedef logic [`BUS_NUM_TGT-1:0] tgt_sel_t;

    // Owner of the current transfer
    typedef enum logic [1:0] {
        INIT_NONE = 2'b00,
        INIT_1    = 2'b01,
        INIT_2    = 2'b10
    } init_id_t;

endpackage

/* logic/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              req1,
    input  logic              req2,
    input  logic              xfer_done,
    output logic              grant1,
    output logic              grant2,
    output bus_pkg::init_id_t grant_owner
);

    import bus_pkg::*;

    init_id_t owner_q;
    // Set when initiator 2 was served last
    logic     last2_q;

    // One owner at a time, held until the controller reports completion
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            owner_q <= INIT_NONE;
            last2_q <= 1'b0;
        end else begin
            if (owner_q != INIT_NONE) begin
                if (xfer_done) begin
                    owner_q <= INIT_NONE;
                end
            end else if (req1 && (!req2 || last2_q)) begin
                owner_q <= INIT_1;
                last2_q <= 1'b0;
            end else if (req2) begin
                owner_q <= INIT_2;
                last2_q <= 1'b1;
            end
        end
    end

    assign grant_owner = owner_q;
    assign grant1      = (owner_q == INIT_1);
    assign grant2      = (owner_q == INIT_2);

endmodule

/* logic/addr_decoder.sv */
`timescale 1ns/1ps
`include "bus_defs.svh"

module addr_decoder (
    input  logic [`BUS_ADDR_W-1:0] addr,
    output bus_pkg::tgt_sel_t      sel,
    output logic [`BUS_ADDR_W-1:0] offset,
    output logic                   unmapped
);

    // Region table, index matches the select bit
    localparam logic [`BUS_NUM_TGT-1:0][`BUS_ADDR_W-1:0] BASE = {
        `TGT2_BASE,
        `TGT1_BASE,
        `TGT0_BASE
    };
    // One extra bit so a full-size region still fits
    localparam logic [`BUS_NUM_TGT-1:0][`BUS_ADDR_W:0] SIZE = {
        (`BUS_ADDR_W+1)'(`TGT2_SIZE),
        (`BUS_ADDR_W+1)'(`TGT1_SIZE),
        (`BUS_ADDR_W+1)'(`TGT0_SIZE)
    };

    logic [`BUS_NUM_TGT-1:0][`BUS_ADDR_W-1:0] rel;
    logic [`BUS_NUM_TGT-1:0]                  hit;

    always_comb begin
        offset = '0;
        for (int i = 0; i < `BUS_NUM_TGT; i++) begin
            rel[i] = addr - BASE[i];
            hit[i] = (addr >= BASE[i]) && ({1'b0, rel[i]} < SIZE[i]);
            // Regions never overlap, so at most one term survives
            if (hit[i]) begin
                offset = offset | rel[i];
            end
        end
    end

    assign sel      = hit;
    assign unmapped = ~|hit;

endmodule

/* logic/xfer_controller.sv */
`timescale 1ns/1ps
`include "bus_defs.svh"

module xfer_controller (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  bus_pkg::init_id_t                         grant_owner,
    input  bus_pkg::bus_cmd_t                         init1_cmd,
    input  bus_pkg::bus_cmd_t                         init2_cmd,
    output logic [`BUS_ADDR_W-1:0]                    dec_addr,
    input  bus_pkg::tgt_sel_t                         dec_sel,
    input  logic [`BUS_ADDR_W-1:0]                    dec_offset,
    input  logic                                      dec_unmapped,
    output bus_pkg::tgt_sel_t                         tgt_valid,
    output bus_pkg::tgt_cmd_t                         tgt_cmd,
    input  logic [`BUS_NUM_TGT-1:0]                   tgt_ack,
    input  logic [`BUS_NUM_TGT-1:0][`BUS_DATA_W-1:0]  tgt_rdata,
    output logic                                      init1_ack,
    output logic                                      init2_ack,
    output bus_pkg::bus_rsp_t                         init_rsp,
    output logic                                      xfer_done
);

    import bus_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'b00,
        ST_ISSUE = 2'b01,
        ST_WAIT  = 2'b10,
        ST_RESP  = 2'b11
    } state_t;

    state_t                 state;
    init_id_t               owner_q;
    bus_cmd_t               cmd_q;
    logic                   tgt_hit;
    logic [`BUS_DATA_W-1:0] rdata_mux;

    // Latched address goes through the decoder while in ISSUE
    assign dec_addr = cmd_q.addr;

    // Only the ack of the selected target counts
    assign tgt_hit = |(tgt_ack & tgt_valid);

    always_comb begin
        rdata_mux = '0;
        for (int i = 0; i < `BUS_NUM_TGT; i++) begin
            if (tgt_valid[i]) begin
                rdata_mux = rdata_mux | tgt_rdata[i];
            end
        end
    end

    // Control path
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            owner_q   <= INIT_NONE;
            tgt_valid <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (grant_owner != INIT_NONE) begin
                        owner_q <= grant_owner;
                        state   <= ST_ISSUE;
                    end
                end
                ST_ISSUE: begin
                    // Unmapped access skips the targets entirely
                    if (dec_unmapped) begin
                        state <= ST_RESP;
                    end else begin
                        tgt_valid <= dec_sel;
                        state     <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (tgt_hit) begin
                        tgt_valid <= '0;
                        state     <= ST_RESP;
                    end
                end
                ST_RESP: begin
                    owner_q <= INIT_NONE;
                    state   <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Command and response payload
    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE: begin
                if (grant_owner == INIT_1) begin
                    cmd_q <= init1_cmd;
                end else if (grant_owner == INIT_2) begin
                    cmd_q <= init2_cmd;
                end
            end
            ST_ISSUE: begin
                tgt_cmd.offset <= dec_offset;
                tgt_cmd.wdata  <= cmd_q.wdata;
                tgt_cmd.write  <= cmd_q.write;
                if (dec_unmapped) begin
                    init_rsp.rdata <= '0;
                    init_rsp.err   <= 1'b1;
                end
            end
            ST_WAIT: begin
                // Read data is taken in the ack cycle
                if (tgt_hit) begin
                    init_rsp.rdata <= rdata_mux;
                    init_rsp.err   <= 1'b0;
                end
            end
            default: begin
            end
        endcase
    end

    // One-cycle completion, steered to the owner
    assign xfer_done = (state == ST_RESP);
    assign init1_ack = xfer_done && (owner_q == INIT_1);
    assign init2_ack = xfer_done && (owner_q == INIT_2);

endmodule

/* logic/bus_interconnect.sv */
`timescale 1ns/1ps
`include "bus_defs.svh"

module bus_interconnect (
    input  logic                                      clk,
    input  logic                                      rst_n,

    // Initiator 1
    input  logic                                      init1_req,
    input  bus_pkg::bus_cmd_t                         init1_cmd,
    output logic                                      init1_grant,
    output logic                                      init1_ack,
    output bus_pkg::bus_rsp_t                         init1_rsp,

    // Initiator 2
    input  logic                                      init2_req,
    input  bus_pkg::bus_cmd_t                         init2_cmd,
    output logic                                      init2_grant,
    output logic                                      init2_ack,
    output bus_pkg::bus_rsp_t                         init2_rsp,

    // Targets
    output bus_pkg::tgt_sel_t                         tgt_valid,
    output bus_pkg::tgt_cmd_t                         tgt_cmd,
    input  logic [`BUS_NUM_TGT-1:0]                   tgt_ack,
    input  logic [`BUS_NUM_TGT-1:0][`BUS_DATA_W-1:0]  tgt_rdata
);

    import bus_pkg::*;

    init_id_t               grant_owner;
    logic                   xfer_done;
    logic [`BUS_ADDR_W-1:0] dec_addr;
    tgt_sel_t               dec_sel;
    logic [`BUS_ADDR_W-1:0] dec_offset;
    logic                   dec_unmapped;
    bus_rsp_t               init_rsp;

    bus_arbiter u_bus_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .req1        (init1_req),
        .req2        (init2_req),
        .xfer_done   (xfer_done),
        .grant1      (init1_grant),
        .grant2      (init2_grant),
        .grant_owner (grant_owner)
    );

    addr_decoder u_addr_decoder (
        .addr     (dec_addr),
        .sel      (dec_sel),
        .offset   (dec_offset),
        .unmapped (dec_unmapped)
    );

    xfer_controller u_xfer_controller (
        .clk          (clk),
        .rst_n        (rst_n),
        .grant_owner  (grant_owner),
        .init1_cmd    (init1_cmd),
        .init2_cmd    (init2_cmd),
        .dec_addr     (dec_addr),
        .dec_sel      (dec_sel),
        .dec_offset   (dec_offset),
        .dec_unmapped (dec_unmapped),
        .tgt_valid    (tgt_valid),
        .tgt_cmd      (tgt_cmd),
        .tgt_ack      (tgt_ack),
        .tgt_rdata    (tgt_rdata),
        .init1_ack    (init1_ack),
        .init2_ack    (init2_ack),
        .init_rsp     (init_rsp),
        .xfer_done    (xfer_done)
    );

    // Shared response word, qualified by each initiator's own ack
    assign init1_rsp = init_rsp;
    assign init2_rsp = init_rsp;

endmodule

/* dv/bus_checker.sv */
`timescale 1ns/1ps
`include "bus_defs.svh"

module bus_checker (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    init1_grant,
    input logic                    init1_ack,
    input logic                    init2_grant,
    input logic                    init2_ack,
    input bus_pkg::tgt_sel_t       tgt_valid,
    input logic [`BUS_NUM_TGT-1:0] tgt_ack
);

    // Failed assertion count, polled by the testbench
    int fail_count = 0;

    grants_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(init1_grant && init2_grant))
        else begin
            fail_count++;
            $error("both initiators hold a grant");
        end

    valid_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(tgt_valid))
        else begin
            fail_count++;
            $error("more than one tgt_valid bit set");
        end

    // Valid may only drop once its ack was sampled
    for (genvar i = 0; i < `BUS_NUM_TGT; i++) begin : g_valid_hold
        valid_held: assert property (@(posedge clk) disable iff (!rst_n)
            tgt_valid[i] && !tgt_ack[i] |=> tgt_valid[i])
            else begin
                fail_count++;
                $error("tgt_valid dropped before its ack");
            end
    end

    ack1_granted: assert property (@(posedge clk) disable iff (!rst_n)
        init1_ack |-> init1_grant)
        else begin
            fail_count++;
            $error("init1_ack without init1_grant");
        end

    ack2_granted: assert property (@(posedge clk) disable iff (!rst_n)
        init2_ack |-> init2_grant)
        else begin
            fail_count++;
            $error("init2_ack without init2_grant");
        end

endmodule

bind bus_interconnect bus_checker u_bus_checker (
    .clk         (clk),
    .rst_n       (rst_n),
    .init1_grant (init1_grant),
    .init1_ack   (init1_ack),
    .init2_grant (init2_grant),
    .init2_ack   (init2_ack),
    .tgt_valid   (tgt_valid),
    .tgt_ack     (tgt_ack)
);

/* dv/tb_bus_interconnect.sv */
`timescale 1ns/1ps
`include "bus_defs.svh"

module tb_bus_interconnect;

    import bus_pkg::*;

    localparam int DRIVE_DLY    = 2;
    localparam int RESET_CYCLES = 5;
    localparam int N_DIRECTED   = 14;
    localparam int N_ALT        = 8;
    localparam int N_RANDOM     = 150;
    localparam int TOTAL_XFERS  = N_DIRECTED + 2 * N_ALT + 2 * N_RANDOM;
    localparam logic [4:0][15:0] BAD_ADDR = {
        16'h0800, 16'h3fff, 16'h5000, 16'h9000, 16'hc123
    };

    logic                                    clk;
    logic                                    rst_n;
    logic                                    init1_req;
    bus_cmd_t                                init1_cmd;
    logic                                    init1_grant;
    logic                                    init1_ack;
    bus_rsp_t                                init1_rsp;
    logic                                    init2_req;
    bus_cmd_t                                init2_cmd;
    logic                                    init2_grant;
    logic                                    init2_ack;
    bus_rsp_t                                init2_rsp;
    tgt_sel_t                                tgt_valid;
    tgt_cmd_t                                tgt_cmd;
    logic [`BUS_NUM_TGT-1:0]                 tgt_ack;
    logic [`BUS_NUM_TGT-1:0][`BUS_DATA_W-1:0] tgt_rdata;

    // Command each initiator currently has on the bus
    bus_cmd_t               cur_cmd [0:2];
    logic [`BUS_DATA_W-1:0] ref_mem [0:65535];
    logic [`BUS_DATA_W-1:0] tgt_mem [0:2][0:4095];
    int                     fwd_count;
    int                     mapped_done;
    int                     done_count;
    int                     last_served;
    logic                   prev_req1;
    logic                   prev_req2;
    logic                   prev_grant1;
    logic                   prev_grant2;
    string                  test_name;

    bus_interconnect u_bus_interconnect (
        .clk         (clk),
        .rst_n       (rst_n),
        .init1_req   (init1_req),
        .init1_cmd   (init1_cmd),
        .init1_grant (init1_grant),
        .init1_ack   (init1_ack),
        .init1_rsp   (init1_rsp),
        .init2_req   (init2_req),
        .init2_cmd   (init2_cmd),
        .init2_grant (init2_grant),
        .init2_ack   (init2_ack),
        .init2_rsp   (init2_rsp),
        .tgt_valid   (tgt_valid),
        .tgt_cmd     (tgt_cmd),
        .tgt_ack     (tgt_ack),
        .tgt_rdata   (tgt_rdata)
    );

    always #20 clk = ~clk;

    function automatic int region_base(input int t);
        case (t)
            0:       return `TGT0_BASE;
            1:       return `TGT1_BASE;
            default: return `TGT2_BASE;
        endcase
    endfunction

    function automatic int region_size(input int t);
        case (t)
            0:       return `TGT0_SIZE;
            1:       return `TGT1_SIZE;
            default: return `TGT2_SIZE;
        endcase
    endfunction

    // Target index for an address or -1 when unmapped
    function automatic int decode_target(input logic [15:0] addr);
        for (int t = 0; t < `BUS_NUM_TGT; t++) begin
            if (int'(addr) >= region_base(t) && int'(addr) < region_base(t) + region_size(t)) begin
                return t;
            end
        end
        return -1;
    endfunction

    function automatic logic [7:0] fill_byte(input int a);
        return 8'(a ^ (a >> 8) ^ 8'ha5);
    endfunction

    function automatic bus_cmd_t make_cmd(input logic [15:0] addr, input logic [7:0] wdata,
                                          input logic write);
        bus_cmd_t cmd;
        cmd.addr  = addr;
        cmd.wdata = wdata;
        cmd.write = write;
        return cmd;
    endfunction

    // Mostly small offsets so reads land on earlier writes
    function automatic bus_cmd_t random_cmd();
        int       kind;
        int       t;
        int       off;
        bus_cmd_t cmd;
        kind = $urandom % 10;
        t    = kind % 3;
        if ($urandom % 4 == 0) begin
            off = $urandom % region_size(t);
        end else begin
            off = $urandom % 32;
        end
        cmd.addr = 16'(region_base(t) + off);
        if (kind == 0) begin
            cmd.addr = 16'h0800 + 16'($urandom % 16'h3800);
        end else if (kind == 1) begin
            cmd.addr = 16'hc000 + 16'($urandom % 16'h4000);
        end
        cmd.wdata = 8'($urandom);
        cmd.write = 1'($urandom);
        return cmd;
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_rsp(input bus_rsp_t exp, input bus_rsp_t act, input logic check_data);
        if (act.err !== exp.err || (check_data && act.rdata !== exp.rdata)) begin
            fail_run($sformatf(
                "Mismatch in %s: rsp expected rdata=%02h err=%0b, actual rdata=%02h err=%0b",
                test_name, exp.rdata, exp.err, act.rdata, act.err));
        end
    endtask

    task automatic compare_tgt_cmd(input tgt_cmd_t exp, input tgt_cmd_t act);
        if (act !== exp) begin
            fail_run($sformatf("Mismatch in %s: tgt_cmd expected %h, actual %h",
                test_name, exp, act));
        end
    endtask

    // A sole requester wins and a tie goes to the one not served last
    task automatic check_grant(input int winner);
        int exp;
        exp = 0;
        if (prev_req1 && prev_req2) begin
            exp = (last_served == 0) ? winner : 3 - last_served;
        end else if (prev_req1) begin
            exp = 1;
        end else if (prev_req2) begin
            exp = 2;
        end else begin
            fail_run("a grant was issued with no request pending");
        end
        if (winner != exp) begin
            fail_run($sformatf("grant went to initiator %0d, initiator %0d was due", winner, exp));
        end
        last_served = winner;
    endtask

    task automatic serve_target(input int t);
        int       owner;
        int       delay;
        bus_cmd_t cmd;
        tgt_cmd_t exp;
        forever begin
            @(negedge clk);
            if (rst_n && tgt_valid[t]) begin
                owner = init1_grant ? 1 : (init2_grant ? 2 : 0);
                if (owner == 0) begin
                    fail_run($sformatf("target %0d saw tgt_valid with no grant", t));
                end
                cmd = cur_cmd[owner];
                if (decode_target(cmd.addr) != t) begin
                    fail_run($sformatf("command for %04h reached target %0d", cmd.addr, t));
                end
                exp.offset = 16'(int'(cmd.addr) - region_base(t));
                exp.wdata  = cmd.wdata;
                exp.write  = cmd.write;
                compare_tgt_cmd(exp, tgt_cmd);
                fwd_count++;
                delay = 1 + $urandom % 6;
                repeat (delay) @(posedge clk);
                #DRIVE_DLY;
                tgt_ack[t]   = 1'b1;
                tgt_rdata[t] = tgt_mem[t][int'(tgt_cmd.offset)];
                if (tgt_cmd.write) begin
                    tgt_mem[t][int'(tgt_cmd.offset)] = tgt_cmd.wdata;
                end
                @(posedge clk);
                #DRIVE_DLY;
                tgt_ack[t]   = 1'b0;
                tgt_rdata[t] = '0;
            end
        end
    endtask

    task automatic do_transfer(input int n, input bus_cmd_t cmd);
        int       tgt;
        logic     got_ack;
        bus_rsp_t exp_rsp;
        bus_rsp_t act_rsp;
        tgt = decode_target(cmd.addr);
        cur_cmd[n] = cmd;
        @(posedge clk);
        #DRIVE_DLY;
        if (n == 1) begin
            init1_cmd = cmd;
            init1_req = 1'b1;
        end else begin
            init2_cmd = cmd;
            init2_req = 1'b1;
        end
        got_ack = 1'b0;
        while (!got_ack) begin
            @(negedge clk);
            got_ack = (n == 1) ? init1_ack : init2_ack;
        end
        if (!((n == 1) ? init1_grant : init2_grant)) begin
            fail_run($sformatf("initiator %0d got an ack without its grant", n));
        end
        act_rsp       = (n == 1) ? init1_rsp : init2_rsp;
        exp_rsp.err   = (tgt < 0);
        exp_rsp.rdata = (tgt < 0 || cmd.write) ? '0 : ref_mem[cmd.addr];
        compare_rsp(exp_rsp, act_rsp, !exp_rsp.err && !cmd.write);
        if (tgt >= 0) begin
            mapped_done++;
            if (cmd.write) begin
                ref_mem[cmd.addr] = cmd.wdata;
            end
        end
        if (fwd_count != mapped_done) begin
            fail_run($sformatf("%0d commands reached targets for %0d mapped transfers",
                fwd_count, mapped_done));
        end
        done_count++;
        @(posedge clk);
        #DRIVE_DLY;
        if (n == 1) begin
            init1_req = 1'b0;
        end else begin
            init2_req = 1'b0;
        end
    endtask

    task automatic run_initiator(input int n, input int count, input int max_gap);
        for (int i = 0; i < count; i++) begin
            do_transfer(n, random_cmd());
            repeat ($urandom % (max_gap + 1)) @(posedge clk);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n) begin
            if (u_bus_interconnect.u_bus_checker.fail_count != 0) begin
                fail_run("a bus handshake assertion failed");
            end
            if ((init1_ack && !init1_req) || (init2_ack && !init2_req)) begin
                fail_run("an ack arrived for an initiator with no request");
            end
            if ((init1_grant || init2_grant) && !prev_grant1 && !prev_grant2) begin
                check_grant(init1_grant ? 1 : 2);
            end
        end
        prev_req1   = init1_req;
        prev_req2   = init2_req;
        prev_grant1 = init1_grant;
        prev_grant2 = init2_grant;
    end

    initial begin
        repeat (RESET_CYCLES + TOTAL_XFERS * 20) @(posedge clk);
        fail_run($sformatf("timeout with %0d of %0d transfers done", done_count, TOTAL_XFERS));
    end

    initial begin
        void'($urandom(32'he10f_c6e5));
        clk         = 1'b0;
        rst_n       = 1'b0;
        init1_req   = 1'b0;
        init1_cmd   = '0;
        init2_req   = 1'b0;
        init2_cmd   = '0;
        tgt_ack     = '0;
        tgt_rdata   = '0;
        fwd_count   = 0;
        mapped_done = 0;
        done_count  = 0;
        last_served = 0;
        prev_req1   = 1'b0;
        prev_req2   = 1'b0;
        prev_grant1 = 1'b0;
        prev_grant2 = 1'b0;
        test_name   = "reset";
        for (int a = 0; a < 65536; a++) begin
            ref_mem[a] = fill_byte(a);
        end
        for (int t = 0; t < `BUS_NUM_TGT; t++) begin
            for (int o = 0; o < region_size(t); o++) begin
                tgt_mem[t][o] = fill_byte(region_base(t) + o);
            end
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        fork
            serve_target(0);
            serve_target(1);
            serve_target(2);
        join_none

        test_name = "region_access";
        for (int t = 0; t < `BUS_NUM_TGT; t++) begin
            do_transfer(1, make_cmd(16'(region_base(t) + 5), 8'(8'h30 + t), 1'b1));
            do_transfer(2, make_cmd(16'(region_base(t) + 5), 8'h00, 1'b0));
            do_transfer(2, make_cmd(16'(region_base(t) + region_size(t) - 1), 8'h00, 1'b0));
        end

        test_name = "unmapped";
        for (int i = 0; i < 5; i++) begin
            do_transfer(1 + i % 2, make_cmd(BAD_ADDR[i], 8'(i), 1'(i)));
        end

        // Back-to-back requests from both sides
        test_name = "alternation";
        fork
            run_initiator(1, N_ALT, 0);
            run_initiator(2, N_ALT, 0);
        join

        test_name = "random_mix";
        fork
            run_initiator(1, N_RANDOM, 3);
            run_initiator(2, N_RANDOM, 3);
        join

        repeat (4) @(posedge clk);
        if (done_count == TOTAL_XFERS && fwd_count == mapped_done) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            fail_run($sformatf("%0d of %0d transfers completed", done_count, TOTAL_XFERS));
        end
    end

endmodule

/* verilog.f */
+incdir+logic
logic/bus_pkg.sv
logic/bus_arbiter.sv
logic/addr_decoder.sv
logic/xfer_controller.sv
logic/bus_interconnect.sv
dv/bus_checker.sv
dv/tb_bus_interconnect.sv
